// File: src/mipsCpu_cfg.svh
`ifndef MIPS_CPU_CFG_SVH
`define MIPS_CPU_CFG_SVH

// data memory depth in 32-bit words
// 256 words fill byte addresses 0x000 to 0x3FF
`define DATA_RAM_WORDS 256

// first fetch address after reset
`define PC_RESET 32'h0000_0000

// word address bits of the data RAM, taken from the byte address
// bits [1:0] select a byte and are ignored (word access only)
`define DATA_RAM_ADDR_BITS $clog2(`DATA_RAM_WORDS)

`endif

// File: src/mipsPkg.sv
package mipsPkg;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opSlti  = 6'h0A,
        opAndi  = 6'h0C,
        opOri   = 6'h0D,
        opLui   = 6'h0F,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcodeE;

    // funct field of R-type words, instr[5:0]
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2A
    } functE;

    // operation actually carried out by the ALU
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluSlt = 4'd4,
        aluSll = 4'd5,
        aluLui = 4'd6
    } aluOpE;

    // coarse ALU class from the decoder, refined in the execute unit
    typedef enum logic [1:0] {
        clsAdd   = 2'b00,
        clsSub   = 2'b01,
        clsFunct = 2'b10,
        clsImm   = 2'b11
    } aluClassE;

    typedef struct packed {
        opcodeE     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functE      funct;
    } rFmtT;

    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFmtT;

    typedef struct packed {
        opcodeE      opcode;
        logic [25:0] target26;
    } jFmtT;

    // one instruction word seen through the three MIPS formats
    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
        jFmtT jFmt;
    } instrU;

    typedef struct packed {
        logic     regDst;
        logic     jump;
        logic     jumpAndLink;
        logic     jumpRegister;
        logic     branch;
        logic     branchNe;
        logic     memRead;
        logic     memToReg;
        logic     memWrite;
        logic     aluSrc;
        logic     regWrite;
        logic     shiftLeftLogical;
        logic     loadUpperImm;
        aluClassE aluOp;
    } ctrlT;

endpackage

// File: src/opcodeControl.sv
`timescale 1ns/1ps

module opcodeControl (
    input  mipsPkg::instrU instr,
    output mipsPkg::ctrlT  ctrl
);

    always_comb begin
        // anything not listed below decodes as a no-op
        ctrl = '0;
        case (instr.rFmt.opcode)
            mipsPkg::opRtype: begin
                case (instr.rFmt.funct)
                    mipsPkg::fnAdd, mipsPkg::fnSub, mipsPkg::fnAnd,
                    mipsPkg::fnOr, mipsPkg::fnSlt: begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::clsFunct;
                    end
                    mipsPkg::fnSll: begin
                        ctrl.regDst           = 1'b1;
                        ctrl.regWrite         = 1'b1;
                        ctrl.shiftLeftLogical = 1'b1;
                        ctrl.aluOp            = mipsPkg::clsFunct;
                    end
                    mipsPkg::fnJr: begin
                        ctrl.jumpRegister = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end
            mipsPkg::opJ: begin
                ctrl.jump = 1'b1;
            end
            mipsPkg::opJal: begin
                // link into $ra, the top picks register 31
                ctrl.jump        = 1'b1;
                ctrl.jumpAndLink = 1'b1;
                ctrl.regWrite    = 1'b1;
            end
            mipsPkg::opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = mipsPkg::clsSub;
            end
            mipsPkg::opBne: begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = mipsPkg::clsSub;
            end
            mipsPkg::opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::clsAdd;
            end
            mipsPkg::opSlti, mipsPkg::opAndi, mipsPkg::opOri: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::clsImm;
            end
            mipsPkg::opLui: begin
                ctrl.aluSrc       = 1'b1;
                ctrl.regWrite     = 1'b1;
                ctrl.loadUpperImm = 1'b1;
                ctrl.aluOp        = mipsPkg::clsImm;
            end
            mipsPkg::opLw: begin
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::opSw: begin
                // address add only, aluOp stays clsAdd
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    input  logic        wrEn,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  logic [4:0]  dbgReg,
    output logic [31:0] dbgData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // $zero reads as zero on every port
    always_comb begin
        rsData  = (rsAddr == 5'd0) ? 32'h0 : regs[rsAddr];
        rtData  = (rtAddr == 5'd0) ? 32'h0 : regs[rtAddr];
        dbgData = (dbgReg == 5'd0) ? 32'h0 : regs[dbgReg];
    end

endmodule

// File: src/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  mipsPkg::instrU instr,
    input  mipsPkg::ctrlT  ctrl,
    input  logic [31:0]    rsData,
    input  logic [31:0]    rtData,
    output logic [31:0]    aluResult,
    output logic           aluZero
);

    logic           zeroExt;
    logic [31:0]    immExt;
    logic [31:0]    opA;
    logic [31:0]    opB;
    mipsPkg::aluOpE aluSel;

    // logical immediates are zero extended, everything else sign extended
    assign zeroExt = (instr.iFmt.opcode == mipsPkg::opAndi) ||
                     (instr.iFmt.opcode == mipsPkg::opOri);
    assign immExt  = zeroExt ? {16'h0, instr.iFmt.imm16}
                             : {{16{instr.iFmt.imm16[15]}}, instr.iFmt.imm16};

    // sll shifts rt by shamt, so shamt takes the A side
    assign opA = ctrl.shiftLeftLogical ? {27'h0, instr.rFmt.shamt} : rsData;
    assign opB = ctrl.aluSrc ? immExt : rtData;

    always_comb begin
        aluSel = mipsPkg::aluAdd;
        case (ctrl.aluOp)
            mipsPkg::clsAdd: aluSel = mipsPkg::aluAdd;
            mipsPkg::clsSub: aluSel = mipsPkg::aluSub;
            mipsPkg::clsFunct: begin
                case (instr.rFmt.funct)
                    mipsPkg::fnAdd: aluSel = mipsPkg::aluAdd;
                    mipsPkg::fnSub: aluSel = mipsPkg::aluSub;
                    mipsPkg::fnAnd: aluSel = mipsPkg::aluAnd;
                    mipsPkg::fnOr:  aluSel = mipsPkg::aluOr;
                    mipsPkg::fnSlt: aluSel = mipsPkg::aluSlt;
                    mipsPkg::fnSll: aluSel = mipsPkg::aluSll;
                    default:        aluSel = mipsPkg::aluAdd;
                endcase
            end
            mipsPkg::clsImm: begin
                case (instr.iFmt.opcode)
                    mipsPkg::opSlti: aluSel = mipsPkg::aluSlt;
                    mipsPkg::opAndi: aluSel = mipsPkg::aluAnd;
                    mipsPkg::opOri:  aluSel = mipsPkg::aluOr;
                    mipsPkg::opLui:  aluSel = mipsPkg::aluLui;
                    default:         aluSel = mipsPkg::aluAdd;
                endcase
            end
            default: aluSel = mipsPkg::aluAdd;
        endcase
    end

    always_comb begin
        case (aluSel)
            mipsPkg::aluAdd: aluResult = opA + opB;
            mipsPkg::aluSub: aluResult = opA - opB;
            mipsPkg::aluAnd: aluResult = opA & opB;
            mipsPkg::aluOr:  aluResult = opA | opB;
            // signed compare, result is 0 or 1
            mipsPkg::aluSlt: aluResult = {31'h0, $signed(opA) < $signed(opB)};
            mipsPkg::aluSll: aluResult = opB << opA[4:0];
            mipsPkg::aluLui: aluResult = {opB[15:0], 16'h0};
            default:         aluResult = opA + opB;
        endcase
    end

    // beq and bne compare through the subtraction
    assign aluZero = (aluResult == 32'h0);

endmodule

// File: src/nextPcUnit.sv
`timescale 1ns/1ps

module nextPcUnit (
    input  logic [31:0]    pc,
    input  mipsPkg::instrU instr,
    input  mipsPkg::ctrlT  ctrl,
    input  logic [31:0]    rsData,
    input  logic           aluZero,
    output logic [31:0]    nextPc,
    output logic [31:0]    pcPlus4
);

    logic [31:0] branchOffset;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        branchTaken;

    assign pcPlus4 = pc + 32'd4;

    // word offset, sign extended, relative to pc+4
    assign branchOffset = {{14{instr.iFmt.imm16[15]}}, instr.iFmt.imm16, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;

    // region jump inside the current 256 MB segment
    assign jumpTarget = {pcPlus4[31:28], instr.jFmt.target26, 2'b00};

    assign branchTaken = (ctrl.branch & aluZero) | (ctrl.branchNe & ~aluZero);

    always_comb begin
        if (ctrl.jumpRegister) begin
            nextPc = rsData;
        end else if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

endmodule

// File: src/dataRam.sv
`timescale 1ns/1ps

`include "mipsCpu_cfg.svh"

module dataRam (
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic [31:0] wrData,
    input  logic        wrEn,
    output logic [31:0] rdData
);

    localparam int addrBits = `DATA_RAM_ADDR_BITS;

    logic [31:0]         mem [`DATA_RAM_WORDS];
    logic [addrBits-1:0] wordAddr;

    // byte address to word index, upper bits wrap
    assign wordAddr = addr[addrBits+1:2];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wordAddr] <= wrData;
        end
    end

    // asynchronous read, a lw sees the word in the same cycle
    assign rdData = mem[wordAddr];

endmodule

// File: src/singleCycleCpu.sv
`timescale 1ns/1ps

`include "mipsCpu_cfg.svh"

module singleCycleCpu (
    input  logic           clk,
    input  logic           rstN,
    output logic [31:0]    instrAddr,
    input  mipsPkg::instrU instr,
    input  logic [4:0]     dbgReg,
    output logic [31:0]    dbgData
);

    mipsPkg::ctrlT ctrl;
    logic [31:0]   pc;
    logic [31:0]   nextPc;
    logic [31:0]   pcPlus4;
    logic [31:0]   rsData;
    logic [31:0]   rtData;
    logic [31:0]   aluResult;
    logic          aluZero;
    logic [31:0]   readData;
    logic [31:0]   upperImm;
    logic [31:0]   wbData;
    logic [4:0]    wbReg;
    logic          regWrEn;
    logic          memWrEn;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `PC_RESET;
        end else begin
            pc <= nextPc;
        end
    end

    assign instrAddr = pc;

    // no architectural writes while in reset
    assign regWrEn = ctrl.regWrite & rstN;
    assign memWrEn = ctrl.memWrite & rstN;

    opcodeControl control (
        .instr (instr),
        .ctrl  (ctrl)
    );

    regFile registers (
        .clk     (clk),
        .rstN    (rstN),
        .rsAddr  (instr.rFmt.rs),
        .rtAddr  (instr.rFmt.rt),
        .wrAddr  (wbReg),
        .wrData  (wbData),
        .wrEn    (regWrEn),
        .rsData  (rsData),
        .rtData  (rtData),
        .dbgReg  (dbgReg),
        .dbgData (dbgData)
    );

    execUnit execute (
        .instr     (instr),
        .ctrl      (ctrl),
        .rsData    (rsData),
        .rtData    (rtData),
        .aluResult (aluResult),
        .aluZero   (aluZero)
    );

    nextPcUnit nextPcCalc (
        .pc      (pc),
        .instr   (instr),
        .ctrl    (ctrl),
        .rsData  (rsData),
        .aluZero (aluZero),
        .nextPc  (nextPc),
        .pcPlus4 (pcPlus4)
    );

    dataRam dataMemory (
        .clk    (clk),
        .addr   (aluResult),
        .wrData (rtData),
        .wrEn   (memWrEn),
        .rdData (readData)
    );

    assign upperImm = {instr.iFmt.imm16, 16'h0};

    // write-back priority: lui, link, load, alu
    always_comb begin
        if (ctrl.loadUpperImm) begin
            wbData = upperImm;
        end else if (ctrl.jumpAndLink) begin
            wbData = pcPlus4;
        end else if (ctrl.memToReg) begin
            wbData = readData;
        end else begin
            wbData = aluResult;
        end
    end

    // jal links into $ra
    assign wbReg = ctrl.jumpAndLink ? 5'd31
                 : ctrl.regDst      ? instr.rFmt.rd
                 :                    instr.rFmt.rt;

endmodule

// File: sim/cpuTb_chk.sv
`timescale 1ns/1ps

`include "mipsCpu_cfg.svh"

module cpuTb_chk (
    input logic        clk,
    input logic        rstN,
    input logic [31:0] instrAddr,
    input logic [31:0] instr,
    input logic [31:0] rsData,
    input logic [31:0] rtData,
    input logic [31:0] aluResult,
    input logic        memWrEn
);

    int failCount = 0;

    // fetch addresses are whole words
    assert property (@(posedge clk) disable iff (!rstN) instrAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("instrAddr %h is not word aligned", instrAddr);
        end

    // one reset edge puts the PC back at its start value
    assert property (@(posedge clk) !rstN |=> instrAddr == `PC_RESET)
        else begin
            failCount++;
            $error("PC is %h after reset", instrAddr);
        end

    // $zero on both read ports
    assert property (@(posedge clk) disable iff (!rstN)
        (instr[25:21] == 5'd0) |-> (rsData == 32'h0))
        else begin
            failCount++;
            $error("rs port reads %h from register 0", rsData);
        end
    assert property (@(posedge clk) disable iff (!rstN)
        (instr[20:16] == 5'd0) |-> (rtData == 32'h0))
        else begin
            failCount++;
            $error("rt port reads %h from register 0", rtData);
        end

    assert property (@(posedge clk) !rstN |-> !memWrEn)
        else begin
            failCount++;
            $error("data RAM written during reset");
        end

    // stores stay inside the data RAM
    assert property (@(posedge clk) disable iff (!rstN)
        memWrEn |-> (aluResult < `DATA_RAM_WORDS * 4))
        else begin
            failCount++;
            $error("store address %h outside data RAM", aluResult);
        end

endmodule

bind singleCycleCpu cpuTb_chk chk (
    .clk       (clk),
    .rstN      (rstN),
    .instrAddr (instrAddr),
    .instr     (instr),
    .rsData    (rsData),
    .rtData    (rtData),
    .aluResult (aluResult),
    .memWrEn   (memWrEn)
);

// File: sim/cpuTb.sv
`timescale 1ns/1ps

`include "mipsCpu_cfg.svh"

module cpuTb;

    localparam int progSlots = 256;

    logic           clk;
    logic           rstN;
    logic [31:0]    instrAddr;
    mipsPkg::instrU instr;
    logic [4:0]     dbgReg;
    logic [31:0]    dbgData;

    logic [31:0] progMem [progSlots];
    int          progCount;
    int          traceCycle [$];
    logic [31:0] tracePc [$];
    logic [4:0]  regIndex [$];
    logic [31:0] regValue [$];
    int          checks;
    int          mismatches;
    int          otherErrors;

    singleCycleCpu dut (
        .clk       (clk),
        .rstN      (rstN),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dbgReg    (dbgReg),
        .dbgData   (dbgData)
    );

    always #2 clk = ~clk;

    // instruction memory, follows the PC in the same edge
    always @(instrAddr) begin
        instr <= progMem[instrAddr[9:2]];
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic loadStim(output bit ok);
        int          fd;
        int          wordsLeft;
        int          num;
        logic [31:0] value;
        string       line;
        string       key;

        ok = 1'b0;
        progCount = 0;
        wordsLeft = 0;
        fd = $fopen("sim/cpu_stim.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("could not open sim/cpu_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if (wordsLeft > 0) begin
                void'($sscanf(line, "%h", value));
                progMem[progCount] = value;
                progCount++;
                wordsLeft--;
            end else begin
                void'($sscanf(line, "%s %d %h", key, num, value));
                if (key == "prog") begin
                    wordsLeft = num;
                end else if (key == "pc") begin
                    traceCycle.push_back(num);
                    tracePc.push_back(value);
                end else if (key == "reg") begin
                    regIndex.push_back(num[4:0]);
                    regValue.push_back(value);
                end else begin
                    otherErrors++;
                    $display("unknown line in stim file: %s", line);
                end
            end
        end
        $fclose(fd);
        if (progCount == 0 || wordsLeft != 0) begin
            otherErrors++;
            $display("program in stim file is empty or shorter than its count");
        end else begin
            ok = 1'b1;
        end
    endtask

    initial begin
        int          limit;
        int          cycle;
        int          lastTrace;
        int          assertFails;
        bit          loaded;
        bit          looped;
        logic [31:0] prevPc;
        logic [31:0] r;

        clk = 1'b0;
        rstN <= 1'b0;
        dbgReg <= 5'd0;
        checks = 0;
        mismatches = 0;
        otherErrors = 0;
        void'($urandom(10408));
        loadStim(loaded);
        // add $0 words past the program end, no architectural effect
        for (int i = progCount; i < progSlots; i++) begin
            r = $urandom;
            progMem[i] = {6'h00, r[4:0], r[9:5], 10'h000, 6'h20};
        end
        instr <= progMem[instrAddr[9:2]];

        limit = progCount * 4 + 20;
        lastTrace = 0;
        foreach (traceCycle[i]) begin
            if (traceCycle[i] > lastTrace) begin
                lastTrace = traceCycle[i];
            end
        end

        // PC is held at its reset value while rstN is low
        @(posedge clk);
        @(negedge clk);
        checkValue("instrAddr", instrAddr, `PC_RESET);
        @(posedge clk);
        rstN <= 1'b1;
        cycle = 0;
        looped = 1'b0;
        prevPc = '1;
        // cycle n samples the PC of the n-th instruction after reset
        while (loaded && !(looped && cycle > lastTrace) && cycle <= limit) begin
            @(negedge clk);
            foreach (traceCycle[i]) begin
                if (traceCycle[i] == cycle) begin
                    checkValue("instrAddr", instrAddr, tracePc[i]);
                end
            end
            if (instrAddr === prevPc) begin
                looped = 1'b1;
            end
            prevPc = instrAddr;
            @(posedge clk);
            cycle++;
        end
        if (loaded && !looped) begin
            otherErrors++;
            $display("timeout: run did not reach the final loop within %0d cycles", limit);
        end

        foreach (regIndex[i]) begin
            @(posedge clk);
            dbgReg <= regIndex[i];
            @(negedge clk);
            checkValue($sformatf("reg %0d", regIndex[i]), dbgData, regValue[i]);
        end

        assertFails = dut.chk.failCount;
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, otherErrors, assertFails);
        if (mismatches == 0 && otherErrors == 0 && assertFails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: mipsCpu.f
+incdir+src
src/mipsPkg.sv
src/opcodeControl.sv
src/regFile.sv
src/execUnit.sv
src/nextPcUnit.sv
src/dataRam.sv
src/singleCycleCpu.sv
sim/cpuTb_chk.sv
sim/cpuTb.sv

// File: Bender.yml
package:
  name: mipsCpu

sources:
  - include_dirs:
      - src
    files:
      - src/mipsPkg.sv
      - src/opcodeControl.sv
      - src/regFile.sv
      - src/execUnit.sv
      - src/nextPcUnit.sv
      - src/dataRam.sv
      - src/singleCycleCpu.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/cpuTb_chk.sv
      - sim/cpuTb.sv

// File: sim/cpu_stim.txt
# prog <count>, then one hex instruction word per line
# pc <cycle after reset> <expected PC hex>, reg <index> <expected value hex>
prog 27
20010005  # addi $1, $0, 5
2002FFFD  # addi $2, $0, -3
00221820  # add  $3, $1, $2
00222022  # sub  $4, $1, $2
00442824  # and  $5, $2, $4
00243025  # or   $6, $1, $4
0041382A  # slt  $7, $2, $1
2848FFFE  # slti $8, $2, -2
3049FFF0  # andi $9, $2, 0xfff0
342A8000  # ori  $10, $1, 0x8000
00015900  # sll  $11, $1, 4
3C0C1234  # lui  $12, 0x1234
20000007  # addi $0, $0, 7
AC0A0008  # sw   $10, 8($0)
AC0C000C  # sw   $12, 12($0)
8C0D0008  # lw   $13, 8($0)
8C0E000C  # lw   $14, 12($0)
10210001  # beq  $1, $1, +1
200F0063  # addi $15, $0, 99 (skipped)
14210001  # bne  $1, $1, +1
20100001  # addi $16, $0, 1
0C000017  # jal  0x5c
08000019  # j    0x64
20120077  # addi $18, $0, 0x77
03E00008  # jr   $31
20340064  # addi $20, $1, 100
0800001A  # j    0x68 (final loop)
pc 0 00000000
pc 8 00000020
pc 17 00000044
pc 18 0000004C
pc 19 00000050
pc 20 00000054
pc 21 0000005C
pc 22 00000060
pc 23 00000058
pc 24 00000064
pc 25 00000068
pc 30 00000068
reg 0 00000000
reg 1 00000005
reg 2 FFFFFFFD
reg 3 00000002
reg 4 00000008
reg 5 00000008
reg 6 0000000D
reg 7 00000001
reg 8 00000001
reg 9 0000FFF0
reg 10 00008005
reg 11 00000050
reg 12 12340000
reg 13 00008005
reg 14 12340000
reg 15 00000000
reg 16 00000001
reg 18 00000077
reg 20 00000069
reg 31 00000058
